/* rtl/fetch_types_pkg.sv */
package fetch_types_pkg;

    // ----------------------------------------------------------------------
    // Processor side geometry
    // ----------------------------------------------------------------------

    // One processor data word.
    typedef logic [15:0] word_t;

    // Words in one cache line.
    localparam int WORDS_PER_LINE = 8;

    // Word address with the three word-offset bits dropped.
    typedef logic [11:0] line_addr_t;

    // Whole line with word 0 in the low bits.
    typedef logic [WORDS_PER_LINE*$bits(word_t)-1:0] line_t;

    // ----------------------------------------------------------------------
    // Sequential access predictor
    // ----------------------------------------------------------------------

    // Saturating confidence value.
    typedef logic [1:0] pred_count_t;

    // Prediction holds at or above this confidence.
    localparam pred_count_t PRED_THRESHOLD = 2'd2;

endpackage : fetch_types_pkg

/* rtl/wb_bus_pkg.sv */
package wb_bus_pkg;

    import fetch_types_pkg::*;

    // ----------------------------------------------------------------------
    // Wishbone classic with one whole line per cycle
    // ----------------------------------------------------------------------

    // Master to slave.
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        line_addr_t adr;
        line_t      dat;
    } wb_req_t;

    // Slave to master.
    // Read data is valid only while ack is high.
    typedef struct packed {
        logic  ack;
        line_t dat;
    } wb_rsp_t;

endpackage : wb_bus_pkg

/* rtl/prefetch_buffer.sv */
`timescale 1ns/1ns

module prefetch_buffer
    import fetch_types_pkg::*, wb_bus_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,

    input  logic       i_load,
    input  line_addr_t i_load_addr,
    input  line_t      i_load_line,

    // Data port traffic seen by the buffer.
    input  wb_req_t    i_snoop_req,
    input  logic       i_snoop_ack,

    output logic       o_valid,
    output line_addr_t o_addr,
    output line_t      o_line
);

    logic       valid_q;
    line_addr_t addr_q;
    line_t      line_q;
    logic       snoop_hit;

    // A completed data write to the held line makes it stale.
    assign snoop_hit = i_snoop_req.cyc & i_snoop_req.stb & i_snoop_req.we &
                       i_snoop_ack & (i_snoop_req.adr == addr_q);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (i_load) begin
            valid_q <= 1'b1;
        end else if (snoop_hit) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            addr_q <= i_load_addr;
            line_q <= i_load_line;
        end
    end

    assign o_valid = valid_q;
    assign o_addr  = addr_q;
    assign o_line  = line_q;

endmodule : prefetch_buffer

/* rtl/sequential_predictor.sv */
`timescale 1ns/1ns

module sequential_predictor
    import fetch_types_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,
    input  logic       i_access,
    input  line_addr_t i_addr,
    output logic       o_predict
);

    pred_count_t count_q;
    line_addr_t  last_addr_q;
    logic        last_valid_q;
    logic        is_next;

    assign is_next = last_valid_q & (i_addr == line_addr_t'(last_addr_q + 1'b1));

    always_ff @(posedge clk) begin
        if (i_reset) begin
            count_q      <= '0;
            last_valid_q <= 1'b0;
        end else if (i_access) begin
            last_valid_q <= 1'b1;
            if (!is_next) begin
                count_q <= '0;
            end else if (count_q != '1) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // Last accessed line address.
    always_ff @(posedge clk) begin
        if (i_access) begin
            last_addr_q <= i_addr;
        end
    end

    assign o_predict = (count_q >= PRED_THRESHOLD);

endmodule : sequential_predictor

/* rtl/prefetch_controller.sv */
`timescale 1ns/1ns

module prefetch_controller
    import fetch_types_pkg::*, wb_bus_pkg::*;
(
    input  logic       clk,
    input  logic       i_reset,

    // Instruction side slave port.
    input  wb_req_t    i_ifetch_req,
    output wb_rsp_t    o_ifetch_rsp,

    // Master port towards the arbiter.
    output wb_req_t    o_l2_req,
    input  wb_rsp_t    i_l2_rsp,

    // Prefetch buffer.
    input  logic       i_buf_valid,
    input  line_addr_t i_buf_addr,
    input  line_t      i_buf_line,
    output logic       o_buf_load,
    output line_addr_t o_buf_addr,

    // Predictor.
    input  logic       i_predict,
    output logic       o_access,
    output line_addr_t o_access_addr,

    output logic       o_pf_hit,
    output logic       o_pf_miss
);

    typedef enum logic [1:0] {
        idle,
        respond,
        fetch_line,
        prefetch_line
    } state_t;

    state_t     state;
    state_t     next_state;
    line_addr_t req_addr_q;
    line_t      rsp_line_q;
    logic       hit_q;
    logic       req_valid;
    logic       buf_hit;
    line_addr_t pf_addr;

    assign req_valid = i_ifetch_req.cyc & i_ifetch_req.stb;
    assign buf_hit   = i_buf_valid & (i_buf_addr == i_ifetch_req.adr);
    assign pf_addr   = req_addr_q + 1'b1;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (req_valid) begin
                    next_state = buf_hit ? respond : fetch_line;
                end
            end
            fetch_line: begin
                if (i_l2_rsp.ack) begin
                    next_state = respond;
                end
            end
            respond: begin
                // Predictor has already seen this access.
                next_state = i_predict ? prefetch_line : idle;
            end
            prefetch_line: begin
                if (i_l2_rsp.ack) begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // Request address, hit flag and the line to return.
    always_ff @(posedge clk) begin
        if (state == idle && req_valid) begin
            req_addr_q <= i_ifetch_req.adr;
            hit_q      <= buf_hit;
            if (buf_hit) begin
                rsp_line_q <= i_buf_line;
            end
        end
        if (state == fetch_line && i_l2_rsp.ack) begin
            rsp_line_q <= i_l2_rsp.dat;
        end
    end

    // ----------------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------------

    always_comb begin
        o_l2_req     = '0;
        o_ifetch_rsp = '0;
        o_buf_load   = 1'b0;
        o_access     = 1'b0;
        o_pf_hit     = 1'b0;
        o_pf_miss    = 1'b0;
        case (state)
            idle: begin
                // One strobe per accepted request.
                o_access = req_valid;
            end
            fetch_line: begin
                o_l2_req.cyc = 1'b1;
                o_l2_req.stb = 1'b1;
                o_l2_req.adr = req_addr_q;
            end
            respond: begin
                o_ifetch_rsp.ack = 1'b1;
                o_ifetch_rsp.dat = rsp_line_q;
                o_pf_hit         = hit_q;
                o_pf_miss        = ~hit_q;
            end
            prefetch_line: begin
                o_l2_req.cyc = 1'b1;
                o_l2_req.stb = 1'b1;
                o_l2_req.adr = pf_addr;
                o_buf_load   = i_l2_rsp.ack;
            end
            default: ;
        endcase
    end

    assign o_buf_addr    = pf_addr;
    assign o_access_addr = i_ifetch_req.adr;

endmodule : prefetch_controller

/* rtl/l2_arbiter.sv */
`timescale 1ns/1ns

module l2_arbiter
    import wb_bus_pkg::*;
(
    input  logic    clk,
    input  logic    i_reset,

    input  wb_req_t i_if_req,
    output wb_rsp_t o_if_rsp,

    input  wb_req_t i_data_req,
    output wb_rsp_t o_data_rsp,

    output wb_req_t o_mem_req,
    input  wb_rsp_t i_mem_rsp
);

    typedef enum logic [1:0] {
        idle,
        grant_if,
        grant_data
    } state_t;

    state_t state;
    logic   last_data_q;
    logic   if_pending;
    logic   data_pending;

    assign if_pending   = i_if_req.cyc & i_if_req.stb;
    assign data_pending = i_data_req.cyc & i_data_req.stb;

    // ----------------------------------------------------------------------
    // Round-robin grant decision
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state       <= idle;
            last_data_q <= 1'b1;
        end else begin
            case (state)
                idle: begin
                    if (if_pending && (!data_pending || last_data_q)) begin
                        state       <= grant_if;
                        last_data_q <= 1'b0;
                    end else if (data_pending) begin
                        state       <= grant_data;
                        last_data_q <= 1'b1;
                    end
                end
                grant_if, grant_data: begin
                    // Owner keeps the memory until its ack.
                    if (i_mem_rsp.ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Routing
    // ----------------------------------------------------------------------

    always_comb begin
        o_mem_req  = '0;
        o_if_rsp   = '0;
        o_data_rsp = '0;
        case (state)
            grant_if: begin
                o_mem_req = i_if_req;
                o_if_rsp  = i_mem_rsp;
            end
            grant_data: begin
                o_mem_req  = i_data_req;
                o_data_rsp = i_mem_rsp;
            end
            default: ;
        endcase
    end

endmodule : l2_arbiter

/* rtl/l2_memory.sv */
`timescale 1ns/1ns

module l2_memory
    import fetch_types_pkg::*, wb_bus_pkg::*;
#(
    parameter int L2_LATENCY = 4,
    parameter int MEM_LINES  = 256
) (
    input  logic    clk,
    input  logic    i_reset,
    input  wb_req_t i_req,
    output wb_rsp_t o_rsp
);

    localparam int IDX_W = $clog2(MEM_LINES);
    localparam int CNT_W = $clog2(L2_LATENCY + 1) + 1;

    line_t            mem [MEM_LINES];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] wait_cnt;
    logic             ack_q;
    line_t            rd_line_q;
    logic             req_active;
    logic             access_done;

    assign idx         = i_req.adr[IDX_W-1:0];
    assign req_active  = i_req.cyc & i_req.stb & ~ack_q;
    assign access_done = req_active & (wait_cnt == CNT_W'(L2_LATENCY));

    // Ack comes L2_LATENCY+1 cycles after stb first shows up.
    always_ff @(posedge clk) begin
        if (i_reset) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= access_done;
            if (access_done || !req_active) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access_done) begin
            if (i_req.we) begin
                mem[idx] <= i_req.dat;
            end else begin
                rd_line_q <= mem[idx];
            end
        end
    end

    assign o_rsp = '{ack: ack_q, dat: rd_line_q};

endmodule : l2_memory

/* rtl/line_fetch_top.sv */
`timescale 1ns/1ns

module line_fetch_top
    import fetch_types_pkg::*, wb_bus_pkg::*;
#(
    parameter int L2_LATENCY = 4,
    parameter int MEM_LINES  = 256
) (
    input  logic    clk,
    input  logic    i_reset,
    input  wb_req_t i_ifetch_req,
    output wb_rsp_t o_ifetch_rsp,
    input  wb_req_t i_data_req,
    output wb_rsp_t o_data_rsp,
    output logic    o_pf_hit,
    output logic    o_pf_miss
);

    wb_req_t    if_l2_req;
    wb_rsp_t    if_l2_rsp;
    wb_req_t    mem_req;
    wb_rsp_t    mem_rsp;
    logic       buf_load;
    line_addr_t buf_load_addr;
    logic       buf_valid;
    line_addr_t buf_addr;
    line_t      buf_line;
    logic       access;
    line_addr_t access_addr;
    logic       predict;

    // ----------------------------------------------------------------------
    // Instruction side prefetcher
    // ----------------------------------------------------------------------

    prefetch_controller u_ctrl (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_ifetch_req  (i_ifetch_req),
        .o_ifetch_rsp  (o_ifetch_rsp),
        .o_l2_req      (if_l2_req),
        .i_l2_rsp      (if_l2_rsp),
        .i_buf_valid   (buf_valid),
        .i_buf_addr    (buf_addr),
        .i_buf_line    (buf_line),
        .o_buf_load    (buf_load),
        .o_buf_addr    (buf_load_addr),
        .i_predict     (predict),
        .o_access      (access),
        .o_access_addr (access_addr),
        .o_pf_hit      (o_pf_hit),
        .o_pf_miss     (o_pf_miss)
    );

    // Snoops the data port so a write to the buffered line drops it.
    prefetch_buffer u_buf (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_load      (buf_load),
        .i_load_addr (buf_load_addr),
        .i_load_line (if_l2_rsp.dat),
        .i_snoop_req (i_data_req),
        .i_snoop_ack (o_data_rsp.ack),
        .o_valid     (buf_valid),
        .o_addr      (buf_addr),
        .o_line      (buf_line)
    );

    sequential_predictor u_pred (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_access  (access),
        .i_addr    (access_addr),
        .o_predict (predict)
    );

    // ----------------------------------------------------------------------
    // Shared memory
    // ----------------------------------------------------------------------

    l2_arbiter u_arb (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_if_req   (if_l2_req),
        .o_if_rsp   (if_l2_rsp),
        .i_data_req (i_data_req),
        .o_data_rsp (o_data_rsp),
        .o_mem_req  (mem_req),
        .i_mem_rsp  (mem_rsp)
    );

    l2_memory #(
        .L2_LATENCY (L2_LATENCY),
        .MEM_LINES  (MEM_LINES)
    ) u_mem (
        .clk     (clk),
        .i_reset (i_reset),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
    );

endmodule : line_fetch_top

/* test/tb_line_fetch_tasks.svh */
`ifndef TB_LINE_FETCH_TASKS_SVH
`define TB_LINE_FETCH_TASKS_SVH

// --------------------------------------------------------------------------
// Checks, patterns and the buffer model
// --------------------------------------------------------------------------

task automatic check_line(input string name, input line_t expected, input line_t actual);
    assert (actual === expected) else begin
        error_count++;
        $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
endtask

task automatic check_int(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
        error_count++;
        $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

// Each word mixes the tag, the full line address and its word index.
function automatic line_t make_line(input line_addr_t addr, input logic [3:0] tag);
    line_t line;
    line = '0;
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
        line[i*16 +: 16] = word_t'({tag, addr}) ^ (16'h1111 * 16'(i));
    end
    return line;
endfunction

task automatic predict_access(input line_addr_t addr, output logic exp_hit);
    exp_hit = model_buf_valid && (model_buf_addr == addr);
    if (model_last_valid && addr == line_addr_t'(model_last + 1)) begin
        if (model_conf < CONF_MAX) begin
            model_conf++;
        end
    end else begin
        model_conf = 0;
    end
    model_last       = addr;
    model_last_valid = 1'b1;
    // Confident accesses leave the next line in the buffer.
    if (model_conf >= CONF_THRESHOLD) begin
        model_buf_valid = 1'b1;
        model_buf_addr  = line_addr_t'(addr + 1);
    end
endtask

// --------------------------------------------------------------------------
// Bus transactions
// --------------------------------------------------------------------------

task automatic data_access(input logic write, input line_addr_t addr, input line_t wdata,
                           output line_t rdata);
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = write;
    req.adr = addr;
    req.dat = wdata;
    @(posedge clk);
    data_req <= req;
    @(posedge clk);
    while (data_rsp.ack !== 1'b1) begin
        @(posedge clk);
    end
    rdata = data_rsp.dat;
    data_req <= '0;
endtask

task automatic data_write(input line_addr_t addr, input line_t wdata);
    line_t unused;
    data_access(1'b1, addr, wdata, unused);
    scoreboard[addr] = wdata;
    if (model_buf_valid && model_buf_addr == addr) begin
        model_buf_valid = 1'b0;
    end
endtask

task automatic data_read_check(input line_addr_t addr);
    line_t got;
    data_access(1'b0, addr, '0, got);
    check_line($sformatf("o_data_rsp.dat line %0d", addr), scoreboard[addr], got);
endtask

task automatic ifetch_read(input line_addr_t addr);
    wb_req_t req;
    logic    exp_hit;
    line_t   got;
    logic    got_hit;
    logic    got_miss;
    predict_access(addr, exp_hit);
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.adr = addr;
    @(posedge clk);
    ifetch_req <= req;
    @(posedge clk);
    while (ifetch_rsp.ack !== 1'b1) begin
        @(posedge clk);
    end
    got      = ifetch_rsp.dat;
    got_hit  = pf_hit;
    got_miss = pf_miss;
    ifetch_req <= '0;
    check_line($sformatf("o_ifetch_rsp.dat line %0d", addr), scoreboard[addr], got);
    check_int($sformatf("o_pf_hit for line %0d", addr), int'(exp_hit), int'(got_hit));
    check_int($sformatf("o_pf_miss for line %0d", addr), int'(!exp_hit), int'(got_miss));
endtask

// Pulses of the last ack are counted on the following edge.
task automatic check_pulses(input string test_name, input int hits0, input int misses0,
                            input int exp_hits, input int exp_misses);
    @(posedge clk);
    check_int({test_name, " o_pf_hit pulses"}, exp_hits, hit_count - hits0);
    check_int({test_name, " o_pf_miss pulses"}, exp_misses, miss_count - misses0);
endtask

// --------------------------------------------------------------------------
// Directed tests
// --------------------------------------------------------------------------

task automatic test_data_port();
    for (int i = 0; i < 16; i++) begin
        data_write(line_addr_t'(i), make_line(line_addr_t'(i), 4'h1));
    end
    for (int i = 0; i < 16; i++) begin
        data_read_check(line_addr_t'(i));
    end
endtask

task automatic test_cold_reads();
    int hits0;
    int misses0;
    data_write(12'd40, make_line(12'd40, 4'h1));
    data_write(12'd25, make_line(12'd25, 4'h1));
    hits0   = hit_count;
    misses0 = miss_count;
    ifetch_read(12'd40);
    ifetch_read(12'd10);
    ifetch_read(12'd25);
    check_pulses("cold reads", hits0, misses0, 0, 3);
endtask

task automatic test_sequential_stream();
    int hits0;
    int misses0;
    hits0   = hit_count;
    misses0 = miss_count;
    for (int i = 0; i < 8; i++) begin
        ifetch_read(line_addr_t'(i));
    end
    check_pulses("sequential stream", hits0, misses0, 5, 3);
endtask

task automatic test_snoop_invalidate();
    int hits0;
    int misses0;
    hits0   = hit_count;
    misses0 = miss_count;
    ifetch_read(12'd3);
    ifetch_read(12'd4);
    ifetch_read(12'd5);
    // The write drops the buffered line 6.
    data_write(12'd6, make_line(12'd6, 4'h2));
    ifetch_read(12'd6);
    check_pulses("snoop invalidation", hits0, misses0, 0, 4);
endtask

task automatic test_contention();
    int hits0;
    int misses0;
    hits0   = hit_count;
    misses0 = miss_count;
    fork
        begin
            for (int i = 8; i < 16; i++) begin
                ifetch_read(line_addr_t'(i));
            end
        end
        begin
            for (int i = 0; i < 8; i++) begin
                data_read_check(line_addr_t'(i));
            end
        end
    join
    check_pulses("contention", hits0, misses0, 5, 3);
endtask

`endif

/* test/tb_line_fetch.sv */
`timescale 1ns/1ns

module tb_line_fetch
    import fetch_types_pkg::*, wb_bus_pkg::*;
();

    // About 70 bus transactions of at most about 20 cycles each.
    localparam int TXN_COUNT      = 70;
    localparam int TXN_MAX_CYCLES = 20;
    localparam int TIMEOUT_CYCLES = 3 * TXN_COUNT * TXN_MAX_CYCLES;

    // Predictor rules as seen from outside.
    localparam int CONF_MAX       = 3;
    localparam int CONF_THRESHOLD = 2;

    logic    clk;
    logic    i_reset;
    wb_req_t ifetch_req;
    wb_rsp_t ifetch_rsp;
    wb_req_t data_req;
    wb_rsp_t data_rsp;
    logic    pf_hit;
    logic    pf_miss;

    int      error_count;
    int      hit_count;
    int      miss_count;
    int      cycle_count;

    // Every line written through the data port.
    line_t   scoreboard [4096];

    // Expected prefetch buffer and predictor state.
    logic       model_buf_valid;
    line_addr_t model_buf_addr;
    int         model_conf;
    line_addr_t model_last;
    logic       model_last_valid;

    always #4 clk = ~clk;

    line_fetch_top u_dut (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_ifetch_req (ifetch_req),
        .o_ifetch_rsp (ifetch_rsp),
        .i_data_req   (data_req),
        .o_data_rsp   (data_rsp),
        .o_pf_hit     (pf_hit),
        .o_pf_miss    (pf_miss)
    );

    // ----------------------------------------------------------------------
    // Pulse counters and timeout
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        if (!i_reset) begin
            if (pf_hit) begin
                hit_count <= hit_count + 1;
            end
            if (pf_miss) begin
                miss_count <= miss_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    `include "tb_line_fetch_tasks.svh"

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        clk              = 1'b0;
        i_reset          = 1'b1;
        ifetch_req       = '0;
        data_req         = '0;
        error_count      = 0;
        hit_count        = 0;
        miss_count       = 0;
        cycle_count      = 0;
        model_buf_valid  = 1'b0;
        model_buf_addr   = '0;
        model_conf       = 0;
        model_last       = '0;
        model_last_valid = 1'b0;

        repeat (8) @(posedge clk);
        i_reset <= 1'b0;
        @(posedge clk);
        check_int("o_ifetch_rsp.ack after reset", 0, int'(ifetch_rsp.ack));
        check_int("o_data_rsp.ack after reset", 0, int'(data_rsp.ack));

        test_data_port();
        test_cold_reads();
        test_sequential_stream();
        test_snoop_invalidate();
        test_contention();

        $display("Errors: %0d, hit pulses: %0d, miss pulses: %0d",
                 error_count, hit_count, miss_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_line_fetch

/* filelist.f */
+incdir+test
rtl/fetch_types_pkg.sv
rtl/wb_bus_pkg.sv
rtl/prefetch_buffer.sv
rtl/sequential_predictor.sv
rtl/prefetch_controller.sv
rtl/l2_arbiter.sv
rtl/l2_memory.sv
rtl/line_fetch_top.sv
test/tb_line_fetch.sv

/* Makefile */
SIM       := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_line_fetch
FILELIST  := filelist.f

BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard test/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
